//--- logic/vramPkg.sv
`default_nettype none

package vramPkg;

	// Slow VRAM geometry
	localparam int VramAddrWidth = 15;	// 32K words
	localparam int VramDataWidth = 16;	// One word per location
	localparam int VramDepth = 1 << VramAddrWidth;

	// Four 4-clock slots make one 16-clock access frame
	// Slot index is the top two bits of the cycle count
	typedef enum logic [1:0] {
		FixSlot  = 2'd0,	// Cycles 0~3, fix map attribute
		SprSlotA = 2'd1,	// Cycles 4~7, sprite tile number low word
		SprSlotB = 2'd2,	// Cycles 8~11, sprite palette, upper bits, AA, flip
		CpuSlot  = 2'd3	// Cycles 12~15, one CPU write or read
	} SlotPhase;

endpackage

`default_nettype wire

//--- logic/rasterCounter.sv
`default_nettype none

module rasterCounter #(
	parameter int HTotal = 384,	// Pixels per line
	parameter int VTotal = 264	// Lines per frame
) (
	input  wire        CLK_24M,
	input  wire        nRESETP,
	output logic [8:0] hCount,
	output logic [8:0] vCount
);

	logic [1:0] pixDiv;	// 24MHz down to 6MHz pixel rate
	logic       pixEn;
	logic       hWrap;	// Last pixel of the line
	logic       vWrap;	// Last line of the frame

	assign pixEn = (pixDiv == 2'd3);	// One pixel every 4 clocks
	assign hWrap = (hCount == 9'(HTotal - 1));
	assign vWrap = (vCount == 9'(VTotal - 1));

	// Divider restarts with the slot counter so both stay aligned
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESETP)
			pixDiv <= 2'd0;
		else
			pixDiv <= pixDiv + 2'd1;
	end

	always_ff @(posedge CLK_24M)
	begin
		if (!nRESETP)
		begin
			hCount <= 9'd0;
			vCount <= 9'd0;
		end
		else if (pixEn)
		begin
			if (hWrap)
			begin
				hCount <= 9'd0;	// New line
				// Vertical steps only on the line wrap
				if (vWrap)
					vCount <= 9'd0;
				else
					vCount <= vCount + 9'd1;
			end
			else
				hCount <= hCount + 9'd1;
		end
	end

endmodule

`default_nettype wire

//--- logic/slowVram.sv
`default_nettype none

module slowVram
	import vramPkg::*;
(
	input  wire                      CLK_24M,
	input  wire  [VramAddrWidth-1:0] memAddr,
	input  wire                      memWe,
	input  wire  [VramDataWidth-1:0] memWrData,
	output logic [VramDataWidth-1:0] memRdData
);

	// Single port 32K x 16 array
	logic [VramDataWidth-1:0] mem [VramDepth];

	// Write lands at the clock edge of the write cycle
	always_ff @(posedge CLK_24M)
	begin
		if (memWe)
			mem[memAddr] <= memWrData;
	end

	// Registered read, data follows the address by one clock
	// Old contents come back on a write cycle
	always_ff @(posedge CLK_24M)
	begin
		memRdData <= mem[memAddr];
	end

endmodule

`default_nettype wire

//--- logic/cpuVramPort.sv
`default_nettype none

module cpuVramPort
	import vramPkg::*;
(
	input  wire                      CLK_24M,
	input  wire                      nRESETP,

	// CPU side register strobes
	input  wire                      cpuAddrWe,	// Load address register
	input  wire                      cpuModWe,	// Load modulo register
	input  wire                      cpuDataWe,	// Queue a data write
	input  wire  [VramDataWidth-1:0] cpuWrData,
	output logic [VramDataWidth-1:0] cpuRdData,
	output logic                     cpuBusy,

	// Toward the slot sequencer
	output logic [VramAddrWidth-1:0] vramAddr,
	output logic [VramDataWidth-1:0] wrData,
	output logic                     wrPending,
	input  wire                      wrCommit,	// Write done in the CPU slot
	input  wire                      rdLatch,	// End of a read CPU slot
	input  wire  [VramDataWidth-1:0] memRdData
);

	logic [VramAddrWidth-1:0] modReg;	// Address step after each write
	logic                     acceptWr;

	// Data strobes while busy are dropped
	assign acceptWr = cpuDataWe && !wrPending;
	assign cpuBusy = wrPending;

	// Address and modulo registers
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESETP)
		begin
			vramAddr <= '0;
			modReg <= '0;
		end
		else
		begin
			if (cpuModWe)
				modReg <= cpuWrData[VramAddrWidth-1:0];
			// A fresh address from the CPU wins over the auto step
			if (cpuAddrWe)
				vramAddr <= cpuWrData[VramAddrWidth-1:0];
			else if (wrCommit)
				vramAddr <= vramAddr + modReg;	// Wraps at 15 bits
		end
	end

	// Pending flag, set by the CPU, cleared by the slot commit
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESETP)
			wrPending <= 1'b0;
		else if (wrCommit)
			wrPending <= 1'b0;
		else if (acceptWr)
			wrPending <= 1'b1;
	end

	// Queued write word
	always_ff @(posedge CLK_24M)
	begin
		if (acceptWr)
			wrData <= cpuWrData;
	end

	// Read data register follows the word at the current address
	always_ff @(posedge CLK_24M)
	begin
		if (rdLatch)
			cpuRdData <= memRdData;
	end

endmodule

`default_nettype wire

//--- logic/slowCycle.sv
`default_nettype none

module slowCycle
	import vramPkg::*;
#(
	parameter logic [3:0] FixMapBase = 4'b1110	// Fix map at 0x7000
) (
	input  wire                      CLK_24M,
	input  wire                      nRESETP,

	// Raster position for the fix map
	input  wire  [8:0]               hCount,
	input  wire  [8:0]               vCount,

	// Sprite being fetched
	input  wire  [8:0]               sprNb,
	input  wire  [4:0]               sprTileIdx,	// Tile index within the sprite

	// CPU port
	input  wire                      wrPending,
	input  wire  [VramAddrWidth-1:0] vramAddr,
	input  wire  [VramDataWidth-1:0] wrData,
	output logic                     wrCommit,
	output logic                     rdLatch,

	// Memory side
	output logic [VramAddrWidth-1:0] memAddr,
	output logic                     memWe,
	output logic [VramDataWidth-1:0] memWrData,
	input  wire  [VramDataWidth-1:0] memRdData,

	// Latched attributes
	output logic [11:0]              fixAttrTileNb,
	output logic [3:0]               fixAttrPal,
	output logic [19:0]              sprAttrTileNb,
	output logic [7:0]               sprAttrPal,
	output logic [1:0]               sprAttrAa,	// Auto animation
	output logic [1:0]               sprAttrFlip	// V and H flip
);

	logic [3:0]               cycleSlow;	// 16 clocks = 4 pixels
	SlotPhase                 slot;
	logic                     slotStart;
	logic                     slotEnd;
	logic                     cpuWrote;	// CPU slot of this frame was a write
	logic [VramAddrWidth-1:0] fixAddr;
	logic [15:0]              sprTileNbL;
	logic [3:0]               sprTileNbU;

	assign slot = SlotPhase'(cycleSlow[3:2]);
	assign slotStart = (cycleSlow[1:0] == 2'b00);
	assign slotEnd = (cycleSlow[1:0] == 2'b11);	// Data has settled by here

	// Fix map address is 1110 HHHHHH VVVVV
	assign fixAddr = {FixMapBase, hCount[8:3], vCount[7:3]};

	// Free running frame counter, restarted only by reset
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESETP)
			cycleSlow <= 4'd0;
		else
			cycleSlow <= cycleSlow + 4'd1;
	end

	// Address held for the whole slot
	always_comb
	begin
		case (slot)
			FixSlot:  memAddr = fixAddr;
			SprSlotA: memAddr = {sprNb, sprTileIdx, 1'b0};	// Even word
			SprSlotB: memAddr = {sprNb, sprTileIdx, 1'b1};	// Odd word
			CpuSlot:  memAddr = vramAddr;
		endcase
	end

	// Single write at the first clock of the CPU slot, cycle 12
	assign wrCommit = (slot == CpuSlot) && slotStart && wrPending;
	assign memWe = wrCommit;
	assign memWrData = wrData;

	// Remember the write so the same slot does not also read
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESETP)
			cpuWrote <= 1'b0;
		else if ((slot == CpuSlot) && slotStart)
			cpuWrote <= wrPending;
	end

	// Read strobe at cycle 15 of a read slot
	assign rdLatch = (slot == CpuSlot) && slotEnd && !cpuWrote;

	// Attribute latches at each slot end
	always_ff @(posedge CLK_24M)
	begin
		if (slotEnd)
		begin
			case (slot)
				FixSlot:
				begin
					fixAttrPal <= memRdData[15:12];
					fixAttrTileNb <= memRdData[11:0];
				end
				SprSlotA:
					sprTileNbL <= memRdData;	// Tile number bits 15~0
				SprSlotB:
				begin
					sprAttrPal <= memRdData[15:8];
					sprTileNbU <= memRdData[7:4];	// Tile number bits 19~16
					sprAttrAa <= memRdData[3:2];
					sprAttrFlip <= memRdData[1:0];
				end
				CpuSlot:
				begin
					// CPU read data goes to the port on rdLatch
				end
			endcase
		end
	end

	assign sprAttrTileNb = {sprTileNbU, sprTileNbL};

endmodule

`default_nettype wire

//--- logic/videoAttrTop.sv
`default_nettype none

module videoAttrTop
	import vramPkg::*;
#(
	parameter logic [3:0] FixMapBase = 4'b1110,	// Fix map upper address bits
	parameter int         HTotal = 384,
	parameter int         VTotal = 264
) (
	input  wire                      CLK_24M,
	input  wire                      nRESETP,

	// CPU register interface
	input  wire                      cpuAddrWe,
	input  wire                      cpuModWe,
	input  wire                      cpuDataWe,
	input  wire  [VramDataWidth-1:0] cpuWrData,
	output logic [VramDataWidth-1:0] cpuRdData,
	output logic                     cpuBusy,	// Write still queued

	// Sprite selection from the renderer
	input  wire  [8:0]               sprNb,
	input  wire  [4:0]               sprTileIdx,

	// Attribute outputs
	output logic [11:0]              fixAttrTileNb,
	output logic [3:0]               fixAttrPal,
	output logic [19:0]              sprAttrTileNb,
	output logic [7:0]               sprAttrPal,
	output logic [1:0]               sprAttrAa,
	output logic [1:0]               sprAttrFlip
);

	logic [8:0]               hCount;
	logic [8:0]               vCount;
	logic [VramAddrWidth-1:0] vramAddr;	// CPU address register
	logic [VramDataWidth-1:0] wrData;
	logic                     wrPending;
	logic                     wrCommit;
	logic                     rdLatch;
	logic [VramAddrWidth-1:0] memAddr;
	logic                     memWe;
	logic [VramDataWidth-1:0] memWrData;
	logic [VramDataWidth-1:0] memRdData;

	rasterCounter #(
		.HTotal (HTotal),
		.VTotal (VTotal)
	) u_rasterCounter (
		.CLK_24M (CLK_24M),
		.nRESETP (nRESETP),
		.hCount  (hCount),
		.vCount  (vCount)
	);

	cpuVramPort u_cpuVramPort (
		.CLK_24M   (CLK_24M),
		.nRESETP   (nRESETP),
		.cpuAddrWe (cpuAddrWe),
		.cpuModWe  (cpuModWe),
		.cpuDataWe (cpuDataWe),
		.cpuWrData (cpuWrData),
		.cpuRdData (cpuRdData),
		.cpuBusy   (cpuBusy),
		.vramAddr  (vramAddr),
		.wrData    (wrData),
		.wrPending (wrPending),
		.wrCommit  (wrCommit),
		.rdLatch   (rdLatch),
		.memRdData (memRdData)
	);

	// Slot sequencer owns the memory port
	slowCycle #(
		.FixMapBase (FixMapBase)
	) u_slowCycle (
		.CLK_24M       (CLK_24M),
		.nRESETP       (nRESETP),
		.hCount        (hCount),
		.vCount        (vCount),
		.sprNb         (sprNb),
		.sprTileIdx    (sprTileIdx),
		.wrPending     (wrPending),
		.vramAddr      (vramAddr),
		.wrData        (wrData),
		.wrCommit      (wrCommit),
		.rdLatch       (rdLatch),
		.memAddr       (memAddr),
		.memWe         (memWe),
		.memWrData     (memWrData),
		.memRdData     (memRdData),
		.fixAttrTileNb (fixAttrTileNb),
		.fixAttrPal    (fixAttrPal),
		.sprAttrTileNb (sprAttrTileNb),
		.sprAttrPal    (sprAttrPal),
		.sprAttrAa     (sprAttrAa),
		.sprAttrFlip   (sprAttrFlip)
	);

	slowVram u_slowVram (
		.CLK_24M   (CLK_24M),
		.memAddr   (memAddr),
		.memWe     (memWe),
		.memWrData (memWrData),
		.memRdData (memRdData)
	);

endmodule

`default_nettype wire

//--- testbench/videoAttr_properties.sv
`default_nettype none

module videoAttrProperties
	import vramPkg::*;
(
	input wire                     CLK_24M,
	input wire                     nRESETP,
	input var SlotPhase            slot,
	input wire                     wrPending,
	input wire                     wrCommit,
	input wire                     rdLatch,
	input wire                     memWe,
	input wire [VramAddrWidth-1:0] memAddr,
	input wire [VramAddrWidth-1:0] vramAddr
);

	logic [3:0] frameCycle;	// Own count of the 16-clock frame
	logic       propFail;	// Watched by the testbench

	initial
		propFail = 1'b0;

	// Frame starts at reset and then runs free
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESETP)
			frameCycle <= 4'd0;
		else
			frameCycle <= frameCycle + 4'd1;
	end

	// Sequencer slot follows the frame count
	slotInStep: assert property (@(posedge CLK_24M) disable iff (!nRESETP)
		slot == SlotPhase'(frameCycle[3:2]))
	else
	begin
		propFail = 1'b1;
		$error("Slot sequence out of step with the 16-clock frame");
	end

	// Memory write only at cycle 12, so at most one per frame
	weInCpuSlot: assert property (@(posedge CLK_24M) disable iff (!nRESETP)
		memWe |-> (frameCycle == 4'd12))
	else
	begin
		propFail = 1'b1;
		$error("memWe high outside cycle 12");
	end

	// A queued write is never skipped
	commitWhenPending: assert property (@(posedge CLK_24M) disable iff (!nRESETP)
		(frameCycle == 4'd12) && wrPending |-> wrCommit && memWe)
	else
	begin
		propFail = 1'b1;
		$error("Pending write not committed at cycle 12");
	end

	// CPU slot writes or reads, never both
	noReadAfterWrite: assert property (@(posedge CLK_24M) disable iff (!nRESETP)
		wrCommit |-> ##3 !rdLatch)
	else
	begin
		propFail = 1'b1;
		$error("rdLatch in a slot that wrote");
	end

	readWhenIdle: assert property (@(posedge CLK_24M) disable iff (!nRESETP)
		(frameCycle == 4'd12) && !wrPending |-> ##3 rdLatch)
	else
	begin
		propFail = 1'b1;
		$error("No rdLatch at cycle 15 of an idle CPU slot");
	end

	cpuSlotAddr: assert property (@(posedge CLK_24M) disable iff (!nRESETP)
		(frameCycle >= 4'd12) |-> (memAddr == vramAddr))
	else
	begin
		propFail = 1'b1;
		$error("CPU slot not driving the address register");
	end

endmodule

bind slowCycle videoAttrProperties u_props (.*);

`default_nettype wire

//--- testbench/videoAttrTb.sv
`default_nettype none

module videoAttrTb
	import vramPkg::*;
();

	localparam int ClkPeriod = 100;
	localparam int HTotal = 384;
	localparam int VTotal = 16;	// Short raster frame
	localparam int RasterClocks = HTotal * VTotal * 4;
	localparam int SeqWords = 8;
	localparam int StrideWords = 6;
	localparam int FixWords = 2048;	// 0x7000~0x77FF
	localparam int TestWrites = SeqWords + StrideWords + FixWords + 4;
	localparam int WatchdogClocks = TestWrites * 32 + RasterClocks;

	logic                     CLK_24M;
	logic                     nRESETP;
	logic                     cpuAddrWe;
	logic                     cpuModWe;
	logic                     cpuDataWe;
	logic [VramDataWidth-1:0] cpuWrData;
	logic [VramDataWidth-1:0] cpuRdData;
	logic                     cpuBusy;
	logic [8:0]               sprNb;
	logic [4:0]               sprTileIdx;
	logic [11:0]              fixAttrTileNb;
	logic [3:0]               fixAttrPal;
	logic [19:0]              sprAttrTileNb;
	logic [7:0]               sprAttrPal;
	logic [1:0]               sprAttrAa;
	logic [1:0]               sprAttrFlip;

	logic [VramDataWidth-1:0] refMem [VramDepth];	// Reference VRAM contents
	logic [VramAddrWidth-1:0] refAddr;	// Expected CPU address register
	logic [VramAddrWidth-1:0] refMod;
	logic [15:0]              lfsr;
	int                       clkCnt;	// Clocks since reset, low 4 bits = frame cycle
	logic                     fixCheckOn;

	videoAttrTop #(
		.VTotal (VTotal)
	) u_videoAttrTop (
		.CLK_24M       (CLK_24M),
		.nRESETP       (nRESETP),
		.cpuAddrWe     (cpuAddrWe),
		.cpuModWe      (cpuModWe),
		.cpuDataWe     (cpuDataWe),
		.cpuWrData     (cpuWrData),
		.cpuRdData     (cpuRdData),
		.cpuBusy       (cpuBusy),
		.sprNb         (sprNb),
		.sprTileIdx    (sprTileIdx),
		.fixAttrTileNb (fixAttrTileNb),
		.fixAttrPal    (fixAttrPal),
		.sprAttrTileNb (sprAttrTileNb),
		.sprAttrPal    (sprAttrPal),
		.sprAttrAa     (sprAttrAa),
		.sprAttrFlip   (sprAttrFlip)
	);

	initial
	begin
		CLK_24M = 1'b0;
		forever #(ClkPeriod / 2) CLK_24M = ~CLK_24M;
	end

	always @(posedge CLK_24M)
	begin
		if (!nRESETP)
			clkCnt <= 0;
		else
			clkCnt <= clkCnt + 1;
	end

	task automatic abortRun(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1, "Run stopped");
	endtask

	task automatic reportMismatch(input string msg);
		abortRun($sformatf("FAIL %0t: %s", $time, msg));
	endtask

	// Galois LFSR, one step per bit taken
	function automatic logic [15:0] randBits(input int n);
		logic [15:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
			r = {r[14:0], lfsr[0]};
		end
		return r;
	endfunction

	task automatic tick();
		@(posedge CLK_24M);
		#10;	// Drive after the edge
	endtask

	task automatic waitIdle();
		while (cpuBusy)
			tick();
	endtask

	// Address or modulo register load
	task automatic loadRegister(input logic toModulo, input logic [VramAddrWidth-1:0] value);
		waitIdle();	// A queued write must land first
		cpuWrData = {1'b0, value};
		cpuModWe = toModulo;
		cpuAddrWe = !toModulo;
		tick();
		cpuModWe = 1'b0;
		cpuAddrWe = 1'b0;
		if (toModulo)
			refMod = value;
		else
			refAddr = value;
	endtask

	task automatic writeWord(input logic [VramDataWidth-1:0] data);
		waitIdle();
		cpuWrData = data;
		cpuDataWe = 1'b1;
		tick();
		cpuDataWe = 1'b0;
		refMem[refAddr] = data;
		refAddr = refAddr + refMod;	// 15-bit wrap
	endtask

	task automatic checkRead(input logic [VramAddrWidth-1:0] addr);
		loadRegister(1'b0, addr);
		repeat (32) tick();	// Two frames, read latch is done
		assert (cpuRdData == refMem[addr])
		else
			reportMismatch($sformatf("cpuRdData %h at %h, expected %h",
				cpuRdData, addr, refMem[addr]));
	endtask

	// Fix attribute against the model, mid frame
	always @(negedge CLK_24M)
	begin : fixCheck
		int                       pix;
		logic [8:0]               hPos;
		logic [8:0]               vPos;
		logic [VramAddrWidth-1:0] addr;
		if (fixCheckOn && (clkCnt[3:0] == 4'd8))
		begin
			pix = (clkCnt >> 4) * 4;	// Pixel at the start of this frame
			hPos = 9'(pix % HTotal);
			vPos = 9'((pix / HTotal) % VTotal);
			addr = {4'b1110, hPos[8:3], vPos[7:3]};
			assert ({fixAttrPal, fixAttrTileNb} == refMem[addr])
			else
				reportMismatch($sformatf("fix attribute %h%h at h=%0d v=%0d, expected %h",
					fixAttrPal, fixAttrTileNb, hPos, vPos, refMem[addr]));
		end
	end

	always @(negedge CLK_24M)
	begin
		if (u_videoAttrTop.u_slowCycle.u_props.propFail)
			abortRun("A slot schedule assertion failed, see the error above");
	end

	initial
	begin
		#(WatchdogClocks * ClkPeriod);
		abortRun("Timeout: the run did not finish within the watchdog limit");
	end

	initial
	begin
		logic [VramAddrWidth-1:0] base;
		logic [VramDataWidth-1:0] lowWord;
		logic [VramDataWidth-1:0] highWord;
		lfsr = 16'd44;
		nRESETP = 1'b0;
		cpuAddrWe = 1'b0;
		cpuModWe = 1'b0;
		cpuDataWe = 1'b0;
		cpuWrData = '0;
		sprNb = '0;
		sprTileIdx = '0;
		fixCheckOn = 1'b0;
		refAddr = '0;
		refMod = '0;
		repeat (3) @(posedge CLK_24M);
		#10;
		assert (!cpuBusy && !u_videoAttrTop.memWe && !u_videoAttrTop.wrCommit
			&& !u_videoAttrTop.rdLatch)
		else
			reportMismatch("busy or a strobe high in reset");
		nRESETP = 1'b1;

		// Sequential writes, then readback
		loadRegister(1'b1, 15'd1);
		base = 15'(randBits(15));
		loadRegister(1'b0, base);
		for (int k = 0; k < SeqWords; k++)
			writeWord(randBits(16));
		loadRegister(1'b1, 15'd0);
		for (int k = 0; k < SeqWords; k++)
			checkRead(base + 15'(k));

		// Stride of 32 words
		loadRegister(1'b1, 15'd32);
		base = 15'(randBits(15));
		loadRegister(1'b0, base);
		for (int k = 0; k < StrideWords; k++)
			writeWord(randBits(16));
		for (int k = 0; k < StrideWords; k++)
			checkRead(base + 15'(k * 32));

		// Whole fix map, then one raster frame of fetches
		loadRegister(1'b1, 15'd1);
		loadRegister(1'b0, 15'h7000);
		for (int k = 0; k < FixWords; k++)
			writeWord(randBits(16));
		waitIdle();
		repeat (32) tick();
		fixCheckOn = 1'b1;
		repeat (RasterClocks) tick();
		fixCheckOn = 1'b0;

		// Sprite word pair, selection held
		sprNb = 9'(randBits(9));
		sprTileIdx = 5'(randBits(5));
		base = {sprNb, sprTileIdx, 1'b0};
		loadRegister(1'b0, base);
		writeWord(randBits(16));
		writeWord(randBits(16));
		waitIdle();
		repeat (32) tick();
		lowWord = refMem[base];
		highWord = refMem[base + 15'd1];
		assert ((sprAttrTileNb == {highWord[7:4], lowWord}) && (sprAttrPal == highWord[15:8])
			&& (sprAttrAa == highWord[3:2]) && (sprAttrFlip == highWord[1:0]))
		else
			reportMismatch($sformatf("sprite attributes %h %h %h %h for words %h %h",
				sprAttrTileNb, sprAttrPal, sprAttrAa, sprAttrFlip, lowWord, highWord));

		// Data strobe while busy is dropped
		base = 15'(randBits(15));
		loadRegister(1'b0, base);
		writeWord(randBits(16));
		assert (cpuBusy)
		else
			reportMismatch("cpuBusy low right after a data write");
		cpuWrData = randBits(16);	// Must never reach memory
		cpuDataWe = 1'b1;
		tick();
		cpuDataWe = 1'b0;
		writeWord(randBits(16));	// Lands at base + 1 after one step
		checkRead(base);
		checkRead(base + 15'd1);

		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- videoAttrTop.f
logic/vramPkg.sv
logic/rasterCounter.sv
logic/slowVram.sv
logic/cpuVramPort.sv
logic/slowCycle.sv
logic/videoAttrTop.sv
testbench/videoAttr_properties.sv
testbench/videoAttrTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= videoAttrTb
RTL_TOP   ?= videoAttrTop
FILELIST  ?= videoAttrTop.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  ?= Simulation FAILED
PASS_MSG  ?= Simulation PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
